//--- hdl/rom_3slots.sv
// top level with three cached read slots sharing one SDRAM request port through an arbiter
module rom_3slots import rom_cfg_pkg::*, rom_types_pkg::*; (
    input  logic                clk,
    input  logic                rst,

    // slot 0, bytes
    input  logic [SLOT0_AW-1:0] slot0_addr,
    input  logic                slot0_cs,
    output byte_t               slot0_dout,
    output logic                slot0_ok,

    // slot 1, halfwords
    input  logic [SLOT1_AW-1:0] slot1_addr,
    input  logic                slot1_cs,
    output half_t               slot1_dout,
    output logic                slot1_ok,

    // slot 2, words
    input  logic [SLOT2_AW-1:0] slot2_addr,
    input  logic                slot2_cs,
    output word_t               slot2_dout,
    output logic                slot2_ok,

    // SDRAM controller read port
    output logic                sdram_req,
    output sdram_addr_t         sdram_addr,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  rom_word_t           data_read
);

    // one link per slot, index matches priority
    slot_bus_if bus [NUM_SLOTS] ();

    rom_slot #(
        .payload_t ( byte_t       ),
        .AW        ( SLOT0_AW     ),
        .OFFSET    ( SLOT0_OFFSET )
    ) u_slot0 (
        .clk  ( clk        ),
        .rst  ( rst        ),
        .addr ( slot0_addr ),
        .cs   ( slot0_cs   ),
        .dout ( slot0_dout ),
        .ok   ( slot0_ok   ),
        .bus  ( bus[0]     )
    );

    rom_slot #(
        .payload_t ( half_t       ),
        .AW        ( SLOT1_AW     ),
        .OFFSET    ( SLOT1_OFFSET )
    ) u_slot1 (
        .clk  ( clk        ),
        .rst  ( rst        ),
        .addr ( slot1_addr ),
        .cs   ( slot1_cs   ),
        .dout ( slot1_dout ),
        .ok   ( slot1_ok   ),
        .bus  ( bus[1]     )
    );

    rom_slot #(
        .payload_t ( word_t       ),
        .AW        ( SLOT2_AW     ),
        .OFFSET    ( SLOT2_OFFSET )
    ) u_slot2 (
        .clk  ( clk        ),
        .rst  ( rst        ),
        .addr ( slot2_addr ),
        .cs   ( slot2_cs   ),
        .dout ( slot2_dout ),
        .ok   ( slot2_ok   ),
        .bus  ( bus[2]     )
    );

    rom_slot_arbiter u_arbiter (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .slots      ( bus        ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

endmodule

//--- hdl/rom_cfg_pkg.sv
// sizes and memory map of the three-slot SDRAM ROM reader, imported by the RTL and testbench
package rom_cfg_pkg;

    // SDRAM addresses count 16-bit units, one read returns two of them
    localparam int SDRAM_AW = 22;

    // number of clients in front of the arbiter
    localparam int NUM_SLOTS = 3;

    // slot address widths, each in units of that slot's payload
    // slot 0 reads bytes
    localparam int SLOT0_AW = 10;
    // slot 1 reads halfwords
    localparam int SLOT1_AW = 9;
    // slot 2 reads 32-bit words
    localparam int SLOT2_AW = 8;

    // base of each slot's region in the SDRAM
    // all even, so that every slot word starts on a read boundary
    // each region spans 512 halfwords and the bases sit far apart
    localparam logic [SDRAM_AW-1:0] SLOT0_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SLOT1_OFFSET = 22'h08_0000;
    localparam logic [SDRAM_AW-1:0] SLOT2_OFFSET = 22'h10_0000;

    // memory map
    //   slot 0  bytes      0x000000 .. 0x0001ff
    //   slot 1  halfwords  0x080000 .. 0x0801ff
    //   slot 2  words      0x100000 .. 0x1001ff
    //
    // a slot unit at address a sits in SDRAM word
    //   offset + 2 * (a / units per word)
    // and the low bits of a pick the unit inside the 32-bit word,
    // lower addresses in the lower bits

endpackage

//--- hdl/rom_slot.sv
// read-only client slot with a one-word cache, serving 8, 16 or 32-bit units set by payload_t
module rom_slot import rom_types_pkg::*; #(
    parameter type         payload_t = byte_t,
    parameter int          AW        = 8,
    parameter sdram_addr_t OFFSET    = '0
) (
    input  logic          clk,
    input  logic          rst,

    input  logic [AW-1:0] addr,
    input  logic          cs,
    output payload_t      dout,
    output logic          ok,

    slot_bus_if.slot      bus
);

    // payload width and how many units one SDRAM word holds
    localparam int PW  = $bits(payload_t);
    localparam int UPW = 32 / PW;
    // address bits that select the unit inside the word
    localparam int LW  = $clog2(UPW);

    sdram_addr_t word_addr;
    logic [1:0]  unit_idx;
    logic        hit;

    // cache state
    logic        valid;
    sdram_addr_t tag;
    rom_word_t   cached;

    // word index doubled, since SDRAM addresses count halfwords
    assign word_addr = OFFSET + (sdram_addr_t'(addr >> LW) << 1);

    // zero for the word slot, where UPW is one
    assign unit_idx = 2'(addr % UPW);

    assign hit = valid && (tag == word_addr);

    // answer straight from the cache
    assign ok   = cs && hit;
    assign dout = cached[unit_idx*PW +: PW];

    // a miss asks for the word in the same cycle
    // req falls by itself once the fetched word turns the miss into a hit
    assign bus.req  = cs && !hit;
    assign bus.addr = word_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (bus.sel && bus.rdy) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.sel && bus.rdy) begin
            tag    <= bus.addr;
            cached <= bus.data;
        end
    end

    // the arbiter only strobes a slot that is still waiting
    a_rdy_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        bus.rdy |-> bus.req
    ) else $error("slot got data without a pending request");

    // the granted address went to SDRAM, so it must not move under the grant
    a_addr_held: assert property (
        @(posedge clk) disable iff (rst)
        bus.sel |-> $stable(bus.addr)
    ) else $error("slot address changed during an open fetch");

endmodule

//--- hdl/rom_slot_arbiter.sv
// fixed-priority arbiter that puts one slot at a time on the SDRAM read port with slot 0 first
module rom_slot_arbiter import rom_cfg_pkg::*, rom_types_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    slot_bus_if.arbiter slots [NUM_SLOTS],

    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  rom_word_t   data_read
);

    slot_mask_t  req_vec;
    slot_mask_t  sel;
    slot_mask_t  pending;
    slot_mask_t  grant;
    sdram_addr_t slot_addr [NUM_SLOTS];
    sdram_addr_t grant_addr;
    logic        free;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign req_vec[i]    = slots[i].req;
        assign slot_addr[i]  = slots[i].addr;
        assign slots[i].sel  = sel[i];
        // every slot sees the read bus but only the selected one gets the strobe
        assign slots[i].data = data_read;
        assign slots[i].rdy  = data_rdy & sel[i];
    end

    // the slot being served keeps req high until its word lands, so mask it out
    assign pending = req_vec & ~sel;

    // idle or the open transaction closes this cycle
    assign free = (sel == '0) || data_rdy;

    // lowest pending index wins
    always_comb begin
        grant      = '0;
        grant_addr = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                grant      = slot_mask_t'(1) << i;
                grant_addr = slot_addr[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_req <= 1'b0;
            sel       <= '0;
        end else begin
            // a late ack just keeps the request up
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (free) begin
                sel       <= grant;
                sdram_req <= |pending;
            end
        end
    end

    // address only moves on a new grant
    always_ff @(posedge clk) begin
        if (free && |pending) begin
            sdram_addr <= grant_addr;
        end
    end

    // at most one slot is served and that slot still waits for its word
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(sel) && ((sel & ~req_vec) == '0)
    ) else $error("selected slot is not a single waiting slot");

    // data from the SDRAM must belong to an open transaction
    a_rdy_when_selected: assert property (
        @(posedge clk) disable iff (rst)
        data_rdy |-> (sel != '0)
    ) else $error("data_rdy with no slot selected");

endmodule

//--- hdl/rom_types_pkg.sv
// data types shared by the slots, the arbiter, the top level and the testbench
package rom_types_pkg;

    import rom_cfg_pkg::*;

    // address on the SDRAM request port, in 16-bit units
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // one SDRAM read result
    // bits 15:0 hold the halfword at the even address A
    // bits 31:16 hold the halfword at A+1
    typedef logic [31:0] rom_word_t;

    // client payloads
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;

    // one bit per slot, bit 0 is the highest priority
    // used for the grant and pending masks
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    // inside a halfword the lower-addressed byte is in bits 7:0,
    // so a byte unit b of a cached word sits at bits 8*(b%4) +: 8

endpackage

//--- hdl/slot_bus_if.sv
// link between one cached slot and the arbiter that fetches its words from SDRAM
interface slot_bus_if import rom_types_pkg::*; ();

    // slot side
    // high while the slot misses, held until rdy
    logic        req;
    // aligned SDRAM address of the missing word
    sdram_addr_t addr;

    // arbiter side
    // level from the grant to the data strobe
    logic        sel;
    // copy of the SDRAM read bus
    rom_word_t   data;
    // data strobe for this slot only
    logic        rdy;

    modport slot (
        output req,
        output addr,
        input  sel,
        input  data,
        input  rdy
    );

    modport arbiter (
        input  req,
        input  addr,
        output sel,
        output data,
        output rdy
    );

endinterface

//--- src.f
hdl/rom_cfg_pkg.sv
hdl/rom_types_pkg.sv
hdl/slot_bus_if.sv
hdl/rom_slot.sv
hdl/rom_slot_arbiter.sv
hdl/rom_3slots.sv
test/sdram_rom_model.sv
test/tb_rom_3slots.sv

//--- test/sdram_rom_model.sv
// behavioral SDRAM read port for the testbench, random ack and data delays over a random ROM
module sdram_rom_model import rom_types_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output rom_word_t   data_read
);
    timeunit 1ns;
    timeprecision 100ps;

    // bits 20:19 tell the three slot regions apart, bits 8:0 walk inside one
    logic [15:0] mem [2048];
    logic [31:0] lfsr;
    sdram_addr_t addr_q;
    int          delay;

    // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int mem_index(sdram_addr_t a);
        return int'({a[20:19], a[8:0]});
    endfunction

    initial begin
        lfsr      = 32'h7c48e16d;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 16'(take_bits(16));
        end
        @(negedge clk);
        forever begin
            if (!rst && sdram_req) begin
                delay = int'(take_bits(2));
                repeat (delay) @(negedge clk);
                addr_q    = sdram_addr;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                delay     = 1 + int'(take_bits(2));
                repeat (delay - 1) @(negedge clk);
                data_read = {mem[mem_index(addr_q + 1'b1)], mem[mem_index(addr_q)]};
                data_rdy  = 1'b1;
                @(negedge clk);
                data_rdy  = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

endmodule

//--- test/tb_rom_3slots.sv
// testbench for rom_3slots that runs random client traffic against an SDRAM model and a reference model
module tb_rom_3slots import rom_cfg_pkg::*, rom_types_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACCESSES = 60;
    localparam int TIMEOUT  = 200;

    logic                clk;
    logic                rst;
    logic [SLOT0_AW-1:0] slot0_addr;
    logic                slot0_cs;
    byte_t               slot0_dout;
    logic                slot0_ok;
    logic [SLOT1_AW-1:0] slot1_addr;
    logic                slot1_cs;
    half_t               slot1_dout;
    logic                slot1_ok;
    logic [SLOT2_AW-1:0] slot2_addr;
    logic                slot2_cs;
    word_t               slot2_dout;
    logic                slot2_ok;
    logic                sdram_req;
    sdram_addr_t         sdram_addr;
    logic                sdram_ack;
    logic                data_rdy;
    rom_word_t           data_read;

    // reference state per slot
    logic        miss_wait [NUM_SLOTS];
    logic        done      [NUM_SLOTS];
    logic        ref_valid [NUM_SLOTS];
    sdram_addr_t ref_tag   [NUM_SLOTS];
    sdram_addr_t want      [NUM_SLOTS];
    // open SDRAM transaction as the reference sees it
    int          active;
    logic        acked;
    sdram_addr_t exp_addr;
    logic [31:0] lfsr;

    rom_3slots dut (.*);

    sdram_rom_model rom (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_half(string name, half_t got, half_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(string name, sdram_addr_t got, sdram_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    // halfword from the model ROM with the region decode of the memory map
    function automatic half_t rom_half(sdram_addr_t a);
        return rom.mem[{a[20:19], a[8:0]}];
    endfunction

    // SDRAM counts halfwords, so the word index of the unit is doubled
    function automatic sdram_addr_t aligned(int s, int a);
        case (s)
            0:       return SLOT0_OFFSET + sdram_addr_t'((a / 4) * 2);
            1:       return SLOT1_OFFSET + sdram_addr_t'((a / 2) * 2);
            default: return SLOT2_OFFSET + sdram_addr_t'(a * 2);
        endcase
    endfunction

    function automatic logic ok_of(int s);
        case (s)
            0:       return slot0_ok;
            1:       return slot1_ok;
            default: return slot2_ok;
        endcase
    endfunction

    task automatic drive(int s, int a, logic cs);
        case (s)
            0: begin
                slot0_addr = SLOT0_AW'(a);
                slot0_cs   = cs;
            end
            1: begin
                slot1_addr = SLOT1_AW'(a);
                slot1_cs   = cs;
            end
            default: begin
                slot2_addr = SLOT2_AW'(a);
                slot2_cs   = cs;
            end
        endcase
    endtask

    task automatic check_dout(int s, int a);
        rom_word_t w;
        w = {rom_half(want[s] + 1'b1), rom_half(want[s])};
        case (s)
            0:       check_byte("slot0_dout", slot0_dout, w[8*(a%4) +: 8]);
            1:       check_half("slot1_dout", slot1_dout, w[16*(a%2) +: 16]);
            default: check_word("slot2_dout", slot2_dout, w);
        endcase
    endtask

    task automatic run_client(int s, int n);
        int   aw;
        int   lw;
        int   a;
        int   prev;
        int   cnt;
        int   gap;
        logic reuse;
        logic hit;
        aw   = (s == 0) ? SLOT0_AW : (s == 1) ? SLOT1_AW : SLOT2_AW;
        lw   = 2 - s;
        prev = 0;
        repeat (n) begin
            @(negedge clk);
            reuse = 1'(take_bits(1));
            // reuse keeps the word and picks a new unit inside it
            if (reuse)
                a = ((prev >> lw) << lw) | int'(take_bits(lw));
            else
                a = int'(take_bits(aw));
            prev         = a;
            want[s]      = aligned(s, a);
            hit          = ref_valid[s] && (ref_tag[s] == want[s]);
            done[s]      = 1'b0;
            miss_wait[s] = !hit;
            drive(s, a, 1'b1);
            #1;
            if (ok_of(s) !== hit) begin
                if (hit)
                    abort_run($sformatf("slot %0d missed on a cached word", s));
                else
                    abort_run($sformatf("slot %0d answered before its fetch", s));
            end
            cnt = 0;
            while (!ok_of(s)) begin
                cnt++;
                if (cnt > TIMEOUT)
                    abort_run($sformatf("slot %0d never got ok", s));
                @(negedge clk);
                #1;
            end
            if (!hit && !done[s])
                abort_run($sformatf("slot %0d gave ok without data from SDRAM", s));
            check_dout(s, a);
            miss_wait[s] = 1'b0;
            gap = int'(take_bits(2));
            if (gap > 0) begin
                @(negedge clk);
                drive(s, a, 1'b0);
                repeat (gap - 1) @(negedge clk);
            end
        end
        @(negedge clk);
        drive(s, prev, 1'b0);
    endtask

    // follows grants in priority order and checks the request port each cycle
    initial begin
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (active >= 0 && sdram_ack)
                    acked = 1'b1;
                if (data_rdy && active < 0)
                    abort_run("data_rdy arrived with no open request");
                if (active < 0 || data_rdy) begin
                    if (data_rdy) begin
                        done[active]      = 1'b1;
                        ref_valid[active] = 1'b1;
                        ref_tag[active]   = want[active];
                    end
                    active = -1;
                    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
                        if (miss_wait[s] && !done[s])
                            active = s;
                    end
                    if (active >= 0) begin
                        exp_addr = want[active];
                        acked    = 1'b0;
                    end
                end
                #2;
                if (active >= 0 && !acked) begin
                    if (sdram_req !== 1'b1)
                        abort_run("sdram_req is low while a request waits for ack");
                    check_addr("sdram_addr", sdram_addr, exp_addr);
                end else if (sdram_req !== 1'b0) begin
                    abort_run("sdram_req is high with no request to send");
                end
            end
        end
    end

    initial begin
        lfsr   = 32'h7c48e16d;
        clk    = 1'b0;
        rst    = 1'b1;
        active = -1;
        acked  = 1'b0;
        exp_addr = '0;
        drive(0, 0, 1'b0);
        drive(1, 0, 1'b0);
        drive(2, 0, 1'b0);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            miss_wait[s] = 1'b0;
            done[s]      = 1'b0;
            ref_valid[s] = 1'b0;
            ref_tag[s]   = '0;
            want[s]      = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        if (slot0_ok || slot1_ok || slot2_ok || sdram_req)
            abort_run("outputs are not idle after reset");
        fork
            run_client(0, ACCESSES);
            run_client(1, ACCESSES);
            run_client(2, ACCESSES);
        join
        repeat (4) @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
